// ==== Bender.yml ====
package:
  name: long_exec

sources:
  - hw/lx_pkg.sv
  - hw/long_scoreboard.sv
  - hw/mul_unit.sv
  - hw/div_unit.sv
  - hw/commit_arbiter.sv
  - hw/long_exec_top.sv
  - target: simulation
    files:
      - sim/tb_long_exec.sv

// ==== hw/commit_arbiter.sv ====
module commit_arbiter #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 2
) (
    input  logic                clk,
    input  logic                rst_n,

    // multiply result, pulse, cannot wait
    input  logic                mul_valid_i,
    input  logic [ID_WIDTH-1:0] mul_id_i,
    input  logic [XLEN-1:0]     mul_res_i,

    // divide result, level, waits for ack
    input  logic                div_done_i,
    input  logic [ID_WIDTH-1:0] div_id_i,
    input  logic [XLEN-1:0]     div_res_i,

    input  lx_pkg::reg_addr_t   commit_rd_i,  // looked up by the scoreboard

    output logic                div_ack_o,
    output logic                commit_valid_o,
    output logic [ID_WIDTH-1:0] commit_id_o,
    output logic                wb_valid_o,
    output lx_pkg::reg_addr_t   wb_rd_o,
    output logic [XLEN-1:0]     wb_data_o
);

    logic              wb_valid_q;
    lx_pkg::reg_addr_t wb_rd_q;
    logic [XLEN-1:0]   wb_data_q;

    // fixed priority, the multiplier has no stall path
    assign commit_valid_o = mul_valid_i || div_done_i;
    assign commit_id_o    = mul_valid_i ? mul_id_i : div_id_i;
    assign div_ack_o      = div_done_i && !mul_valid_i;  // divide waits a cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= commit_valid_o;
        end
    end

    // winner data plus its dest register
    always_ff @(posedge clk) begin
        wb_rd_q   <= commit_rd_i;
        wb_data_q <= mul_valid_i ? mul_res_i : div_res_i;
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_data_q;

endmodule

// ==== hw/div_unit.sv ====
module div_unit #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,    // dispatch strobe, any op
    input  lx_pkg::long_op_t    op_i,
    input  logic [XLEN-1:0]     a_i,        // dividend
    input  logic [XLEN-1:0]     b_i,        // divisor
    input  logic [ID_WIDTH-1:0] id_i,
    input  logic                div_ack_i,  // arbiter took the result
    output logic                div_busy_o,
    output logic                div_done_o, // level until ack
    output logic [ID_WIDTH-1:0] div_id_o,
    output logic [XLEN-1:0]     div_res_o
);

    localparam int CNT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [ID_WIDTH-1:0] id_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,     // one shift-subtract per cycle
        S_FIXUP,   // sign restore and corner cases
        S_DONE     // hold result for the arbiter
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             take;
    logic             a_neg, b_neg;
    word_t            a_q, quot_q, rem_q, dvs_q, res_q;
    id_t              id_q;
    logic             neg_quot, neg_rem, is_rem, by_zero;
    logic [XLEN:0]    rem_sh;
    logic [XLEN:0]    diff;
    word_t            quot_fix, rem_fix;

    assign take  = start_i && op_i[2];             // divide class only
    assign a_neg = !op_i[0] && a_i[XLEN-1];        // signed ops look at sign bits
    assign b_neg = !op_i[0] && b_i[XLEN-1];

    // restoring step, borrow in top bit
    assign rem_sh = {rem_q, quot_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    // signed overflow needs no special path
    // |min| / 1 gives min with a positive sign, remainder 0
    assign quot_fix = neg_quot ? -quot_q : quot_q;
    assign rem_fix  = neg_rem ? -rem_q : rem_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (take) begin
                        state_q <= S_RUN;
                        cnt_q   <= '0;
                    end
                end
                S_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(XLEN - 1)) begin
                        state_q <= S_FIXUP;
                    end
                end
                S_FIXUP: state_q <= S_DONE;
                S_DONE: begin
                    if (div_ack_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                if (take) begin
                    a_q      <= a_i;                  // kept for rem by zero
                    quot_q   <= a_neg ? -a_i : a_i;   // dividend magnitude
                    dvs_q    <= b_neg ? -b_i : b_i;
                    rem_q    <= '0;
                    neg_quot <= a_neg ^ b_neg;
                    neg_rem  <= a_neg;                // remainder follows dividend
                    is_rem   <= op_i[1];
                    by_zero  <= (b_i == '0);
                    id_q     <= id_i;
                end
            end
            S_RUN: begin
                if (!diff[XLEN]) begin
                    rem_q  <= diff[XLEN-1:0];
                    quot_q <= {quot_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q  <= rem_sh[XLEN-1:0];
                    quot_q <= {quot_q[XLEN-2:0], 1'b0};
                end
            end
            S_FIXUP: begin
                if (by_zero) begin
                    res_q <= is_rem ? a_q : '1;  // riscv divide by zero
                end else begin
                    res_q <= is_rem ? rem_fix : quot_fix;
                end
            end
            default: ;
        endcase
    end

    assign div_busy_o = (state_q != S_IDLE);  // waiting result keeps it busy
    assign div_done_o = (state_q == S_DONE);
    assign div_id_o   = id_q;
    assign div_res_o  = res_q;

endmodule

// ==== hw/long_exec_top.sv ====
module long_exec_top #(
    parameter int XLEN     = 32,
    parameter int ID_WIDTH = 2   // table holds 2**ID_WIDTH ops
) (
    input  logic              clk,
    input  logic              rst_n,

    // issue stage
    input  logic              issue_valid_i,
    input  lx_pkg::long_op_t  issue_op_i,
    input  lx_pkg::reg_addr_t issue_rs1_i,
    input  lx_pkg::reg_addr_t issue_rs2_i,
    input  lx_pkg::reg_addr_t issue_rd_i,
    input  logic              issue_rd_we_i,
    input  logic [XLEN-1:0]   issue_a_i,
    input  logic [XLEN-1:0]   issue_b_i,
    input  logic              pipe_stall_i,

    output logic              hazard_stall_o,
    output logic              atom_lock_o,

    // writeback port
    output logic              wb_valid_o,
    output lx_pkg::reg_addr_t wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o
);

    logic                dispatch;
    logic [ID_WIDTH-1:0] alloc_id;
    logic                div_busy;
    logic                mul_valid;
    logic [ID_WIDTH-1:0] mul_id;
    logic [XLEN-1:0]     mul_res;
    logic                div_done;
    logic [ID_WIDTH-1:0] div_id;
    logic [XLEN-1:0]     div_res;
    logic                div_ack;
    logic                commit_valid;
    logic [ID_WIDTH-1:0] commit_id;
    lx_pkg::reg_addr_t   commit_rd;

    long_scoreboard #(.ID_WIDTH(ID_WIDTH)) u_sb (
        .clk(clk), .rst_n(rst_n),
        .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i),
        .issue_rs1_i(issue_rs1_i), .issue_rs2_i(issue_rs2_i),
        .issue_rd_i(issue_rd_i), .issue_rd_we_i(issue_rd_we_i),
        .pipe_stall_i(pipe_stall_i), .div_busy_i(div_busy),
        .commit_valid_i(commit_valid), .commit_id_i(commit_id),
        .hazard_stall_o(hazard_stall_o), .dispatch_o(dispatch),
        .alloc_id_o(alloc_id), .commit_rd_o(commit_rd),
        .atom_lock_o(atom_lock_o)
    );

    // units filter the op class themselves
    mul_unit #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) u_mul (
        .clk(clk), .rst_n(rst_n),
        .start_i(dispatch), .op_i(issue_op_i),
        .a_i(issue_a_i), .b_i(issue_b_i), .id_i(alloc_id),
        .mul_valid_o(mul_valid), .mul_id_o(mul_id), .mul_res_o(mul_res)
    );

    div_unit #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) u_div (
        .clk(clk), .rst_n(rst_n),
        .start_i(dispatch), .op_i(issue_op_i),
        .a_i(issue_a_i), .b_i(issue_b_i), .id_i(alloc_id),
        .div_ack_i(div_ack), .div_busy_o(div_busy),
        .div_done_o(div_done), .div_id_o(div_id), .div_res_o(div_res)
    );

    commit_arbiter #(.XLEN(XLEN), .ID_WIDTH(ID_WIDTH)) u_arb (
        .clk(clk), .rst_n(rst_n),
        .mul_valid_i(mul_valid), .mul_id_i(mul_id), .mul_res_i(mul_res),
        .div_done_i(div_done), .div_id_i(div_id), .div_res_i(div_res),
        .commit_rd_i(commit_rd), .div_ack_o(div_ack),
        .commit_valid_o(commit_valid), .commit_id_o(commit_id),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

// ==== hw/long_scoreboard.sv ====
module long_scoreboard #(
    parameter int ID_WIDTH = 2
) (
    input  logic                clk,
    input  logic                rst_n,

    // issue side
    input  logic                issue_valid_i,
    input  lx_pkg::long_op_t    issue_op_i,
    input  lx_pkg::reg_addr_t   issue_rs1_i,
    input  lx_pkg::reg_addr_t   issue_rs2_i,
    input  lx_pkg::reg_addr_t   issue_rd_i,
    input  logic                issue_rd_we_i,
    input  logic                pipe_stall_i,   // stall from the rest of the core
    input  logic                div_busy_i,     // divider holds a divide

    // commit from arbiter
    input  logic                commit_valid_i,
    input  logic [ID_WIDTH-1:0] commit_id_i,

    output logic                hazard_stall_o,
    output logic                dispatch_o,     // one cycle per accepted op
    output logic [ID_WIDTH-1:0] alloc_id_o,
    output lx_pkg::reg_addr_t   commit_rd_o,    // dest of the leaving entry
    output logic                atom_lock_o     // any long op outstanding
);

    localparam int ENTRIES = 1 << ID_WIDTH;

    typedef logic [ID_WIDTH-1:0] id_t;

    // outstanding-entry table
    logic [ENTRIES-1:0] valid_q;
    lx_pkg::reg_addr_t  rd_q [ENTRIES];

    logic [ENTRIES-1:0] live;        // valid and not committing now
    logic               rs1_chk;
    logic               rs2_chk;
    logic               rd_chk;
    logic               raw_hit;
    logic               waw_hit;
    logic               table_full;
    logic               div_block;
    id_t                free_id;

    // x0 never carries a dependency
    assign rs1_chk = (issue_rs1_i != '0);
    assign rs2_chk = (issue_rs2_i != '0);
    assign rd_chk  = (issue_rd_i != '0) && issue_rd_we_i;  // only real writes count

    always_comb begin
        raw_hit = 1'b0;
        waw_hit = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            // an entry that commits this cycle no longer blocks anything
            live[i] = valid_q[i] && !(commit_valid_i && (commit_id_i == id_t'(i)));
            if (live[i]) begin
                if ((rs1_chk && (issue_rs1_i == rd_q[i])) ||
                    (rs2_chk && (issue_rs2_i == rd_q[i]))) begin
                    raw_hit = 1'b1;
                end
                if (rd_chk && (issue_rd_i == rd_q[i])) begin
                    waw_hit = 1'b1;
                end
            end
        end
    end

    // lowest free slot, scan from the top so index 0 wins last
    always_comb begin
        free_id = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!live[i]) begin
                free_id = id_t'(i);
            end
        end
    end

    assign table_full = &live;
    assign div_block  = issue_op_i[2] && div_busy_i;  // one divide at a time

    assign hazard_stall_o = issue_valid_i &&
                            (raw_hit || waw_hit || table_full || div_block);
    assign dispatch_o     = issue_valid_i && !hazard_stall_o && !pipe_stall_i;
    assign alloc_id_o     = free_id;
    assign commit_rd_o    = rd_q[commit_id_i];
    assign atom_lock_o    = |valid_q;

    // valid bits, set after clear so a reused slot stays valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (commit_valid_i) begin
                valid_q[commit_id_i] <= 1'b0;
            end
            if (dispatch_o) begin
                valid_q[free_id] <= 1'b1;
            end
        end
    end

    // dest register per slot
    // no-write ops park x0 so they never match a waw check
    always_ff @(posedge clk) begin
        if (dispatch_o) begin
            rd_q[free_id] <= issue_rd_we_i ? issue_rd_i : '0;
        end
    end

endmodule

// ==== hw/lx_pkg.sv ====
package lx_pkg;

    // architectural register index, x0 is hardwired zero
    typedef logic [4:0] reg_addr_t;

    // long op code
    // bit 2 set marks the divide class (div, divu, rem, remu)
    // for divides bit 1 picks the remainder, bit 0 marks unsigned
    // for multiplies bit 0 picks the high word
    typedef logic [2:0] long_op_t;

    // multiply class
    localparam long_op_t OP_MUL   = 3'b000;  // low word of product
    localparam long_op_t OP_MULHU = 3'b001;  // high word, both unsigned

    // divide class
    localparam long_op_t OP_DIV   = 3'b100;  // signed quotient
    localparam long_op_t OP_DIVU  = 3'b101;  // unsigned quotient
    localparam long_op_t OP_REM   = 3'b110;  // signed remainder
    localparam long_op_t OP_REMU  = 3'b111;  // unsigned remainder

    // codes 010 and 011 are free
    // mulh and mulhsu would go there if the core ever needs them

endpackage

// ==== hw/mul_unit.sv ====
module mul_unit #(
    parameter int XLEN     = 32,  // even width assumed
    parameter int ID_WIDTH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,    // dispatch strobe, any op
    input  lx_pkg::long_op_t    op_i,
    input  logic [XLEN-1:0]     a_i,
    input  logic [XLEN-1:0]     b_i,
    input  logic [ID_WIDTH-1:0] id_i,
    output logic                mul_valid_o,  // single-cycle pulse
    output logic [ID_WIDTH-1:0] mul_id_o,
    output logic [XLEN-1:0]     mul_res_o
);

    localparam int HALF = XLEN / 2;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ID_WIDTH-1:0]  id_t;
    typedef logic [XLEN+HALF-1:0] part_t;   // word times half word

    logic              take;
    logic              s1_valid, s2_valid, s3_valid;
    logic              s1_hi, s2_hi;
    id_t               s1_id, s2_id, s3_id;
    word_t             s1_a, s1_b;
    part_t             s2_plo, s2_phi;
    logic [2*XLEN-1:0] prod;
    word_t             s3_res;

    assign take = start_i && !op_i[2];  // multiply class only

    // full product from the two partial rows
    assign prod = (2*XLEN)'(s2_plo) + {s2_phi, {HALF{1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 operand capture
        s1_a  <= a_i;
        s1_b  <= b_i;
        s1_id <= id_i;
        s1_hi <= (op_i == lx_pkg::OP_MULHU);
        // stage 2 split on b halves
        s2_plo <= s1_a * s1_b[HALF-1:0];
        s2_phi <= s1_a * s1_b[XLEN-1:HALF];
        s2_id  <= s1_id;
        s2_hi  <= s1_hi;
        // stage 3 sum and word select
        s3_res <= s2_hi ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        s3_id  <= s2_id;
    end

    assign mul_valid_o = s3_valid;
    assign mul_id_o    = s3_id;
    assign mul_res_o   = s3_res;

endmodule

// ==== sim/tb_long_exec.sv ====
module tb_long_exec;

    localparam int XLEN  = 32;
    localparam int NROWS = 23;
    localparam int LIMIT = NROWS * 40 + 200;  // cycle budget for the whole run

    logic              clk;
    logic              rst_n;
    logic              issue_valid_i;
    lx_pkg::long_op_t  issue_op_i;
    lx_pkg::reg_addr_t issue_rs1_i, issue_rs2_i, issue_rd_i;
    logic              issue_rd_we_i;
    logic [XLEN-1:0]   issue_a_i, issue_b_i;
    logic              pipe_stall_i;
    logic              hazard_stall_o, atom_lock_o, wb_valid_o;
    lx_pkg::reg_addr_t wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;

    // stimulus table
    lx_pkg::long_op_t  t_op [NROWS];
    lx_pkg::reg_addr_t t_rs1 [NROWS], t_rs2 [NROWS], t_rd [NROWS];
    logic              t_we [NROWS];
    int                t_gap [NROWS];
    int                t_fs [NROWS];     // first hazard sample (0 any, 1 low, 2 high)
    logic              t_fix [NROWS];    // corner row with fixed operands
    logic [XLEN-1:0]   t_a [NROWS], t_b [NROWS];
    int                t_hold [NROWS];   // cycles of pipe_stall_i before issue
    int                nrow;

    // reference state per register
    logic              pend [32];
    logic [XLEN-1:0]   exp_data [32];
    logic              is_mul [32];
    int                iss_cyc [32];
    int                x0_pend, issued, wb_count;
    int                cyc = 0;
    logic [31:0]       rng;

    long_exec_top #(.XLEN(XLEN), .ID_WIDTH(2)) DUT (
        .clk(clk), .rst_n(rst_n),
        .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i),
        .issue_rs1_i(issue_rs1_i), .issue_rs2_i(issue_rs2_i),
        .issue_rd_i(issue_rd_i), .issue_rd_we_i(issue_rd_we_i),
        .issue_a_i(issue_a_i), .issue_b_i(issue_b_i), .pipe_stall_i(pipe_stall_i),
        .hazard_stall_o(hazard_stall_o), .atom_lock_o(atom_lock_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    always #50 clk = !clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == LIMIT) begin
            $display("timeout: writebacks did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] s;
        s = rng;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng = s;
        return s;
    endfunction

    // riscv m-extension rules
    function automatic logic [XLEN-1:0] expected_result(lx_pkg::long_op_t op,
                                                        logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa, sb;
        logic [2*XLEN-1:0]      wide;
        logic                   ovf;
        sa   = a;
        sb   = b;
        wide = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        case (op)
            lx_pkg::OP_MUL:   return wide[XLEN-1:0];
            lx_pkg::OP_MULHU: return wide[2*XLEN-1:XLEN];
            lx_pkg::OP_DIV:   return (b == 0) ? '1 : ovf ? a : XLEN'(sa / sb);
            lx_pkg::OP_DIVU:  return (b == 0) ? '1 : a / b;
            lx_pkg::OP_REM:   return (b == 0) ? a : ovf ? '0 : XLEN'(sa % sb);
            default:          return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run("value mismatch");
        end
    endtask

    task automatic add_row(input lx_pkg::long_op_t op, input lx_pkg::reg_addr_t rs1,
                           input lx_pkg::reg_addr_t rs2, input lx_pkg::reg_addr_t rd,
                           input logic we, input int gap, input int fs,
                           input logic fix = 1'b0, input logic [XLEN-1:0] a = '0,
                           input logic [XLEN-1:0] b = '0, input int hold = 0);
        t_op[nrow]  = op;
        t_rs1[nrow] = rs1;
        t_rs2[nrow] = rs2;
        t_rd[nrow]  = rd;
        t_we[nrow]  = we;
        t_gap[nrow] = gap;
        t_fs[nrow]  = fs;
        t_fix[nrow] = fix;
        t_a[nrow]   = a;
        t_b[nrow]   = b;
        t_hold[nrow] = hold;
        nrow++;
    endtask

    // wait one cycle and look at the writeback port
    task automatic tick();
        @(negedge clk);
        if (wb_valid_o) begin
            wb_count++;
            if (wb_rd_o == 0) begin
                if (x0_pend == 0) stop_run("writeback to x0 with nothing pending there");
                x0_pend--;
            end else begin
                if (!pend[wb_rd_o]) stop_run("writeback to a register with nothing pending");
                check_val("wb_data_o", wb_data_o, exp_data[wb_rd_o]);
                if (is_mul[wb_rd_o]) check_val("multiply latency", cyc - iss_cyc[wb_rd_o], 4);
                pend[wb_rd_o] = 1'b0;
            end
        end
    endtask

    function automatic int outstanding();
        int n;
        n = x0_pend;
        for (int i = 1; i < 32; i++) n += pend[i];
        return n;
    endfunction

    initial begin
        logic accepted;
        logic first;
        clk = 0;
        rst_n = 0;
        rng = 37;
        nrow = 0;
        issue_valid_i = 0;
        issue_op_i = '0;
        issue_rs1_i = '0;
        issue_rs2_i = '0;
        issue_rd_i = '0;
        issue_rd_we_i = 0;
        issue_a_i = '0;
        issue_b_i = '0;
        pipe_stall_i = 0;
        x0_pend = 0;
        issued = 0;
        wb_count = 0;
        for (int i = 0; i < 32; i++) pend[i] = 1'b0;

        add_row(lx_pkg::OP_MUL,   1, 2, 3, 1, 0, 1);
        add_row(lx_pkg::OP_MULHU, 4, 5, 6, 1, 0, 1);
        add_row(lx_pkg::OP_MUL,   7, 8, 9, 1, 0, 0);
        add_row(lx_pkg::OP_MULHU, 1, 2, 10, 1, 3, 0);
        add_row(lx_pkg::OP_DIV,   1, 2, 11, 1, 0, 0);
        add_row(lx_pkg::OP_MUL,  21, 22, 12, 1, 0, 1);   // overtakes the divide
        add_row(lx_pkg::OP_MUL,  11, 0, 13, 1, 0, 2);    // raw on the divide
        add_row(lx_pkg::OP_REM,   1, 2, 14, 1, 0, 0);
        add_row(lx_pkg::OP_DIV,   1, 2, 15, 1, 0, 2);    // divider still busy
        add_row(lx_pkg::OP_MUL,   5, 6, 15, 1, 0, 2);    // waw on x15
        add_row(lx_pkg::OP_MUL,   0, 0, 0, 1, 0, 1);     // x0 everywhere
        add_row(lx_pkg::OP_MULHU, 0, 0, 15, 0, 0, 1);    // no write so no waw
        add_row(lx_pkg::OP_MUL,   0, 0, 0, 1, 0, 1);     // x0 dest while x0 slots pend
        add_row(lx_pkg::OP_DIVU,  1, 2, 16, 1, 0, 0);
        add_row(lx_pkg::OP_REMU,  0, 0, 17, 1, 0, 0);
        add_row(lx_pkg::OP_DIV,   1, 2, 18, 1, 0, 0, 1, 32'h8000_0000, 32'hffff_ffff);
        add_row(lx_pkg::OP_REM,   1, 2, 19, 1, 0, 0, 1, 32'h8000_0000, 32'hffff_ffff);
        add_row(lx_pkg::OP_DIV,   1, 2, 20, 1, 0, 0, 1, 32'h1234_5678, 32'h0);
        add_row(lx_pkg::OP_REM,   1, 2, 21, 1, 0, 0, 1, 32'h8765_4321, 32'h0);
        add_row(lx_pkg::OP_DIVU,  1, 2, 22, 1, 0, 0, 1, 32'hdead_beef, 32'h0);
        add_row(lx_pkg::OP_REMU,  1, 2, 23, 1, 0, 0, 1, 32'hcafe_f00d, 32'h0);
        add_row(lx_pkg::OP_MUL,   0, 0, 24, 1, 0, 1, 0, 0, 0, 3);  // pipe stall first
        add_row(lx_pkg::OP_REMU,  3, 6, 25, 1, 0, 0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1;
        tick();
        check_val("atom_lock_o", atom_lock_o, 0);
        check_val("hazard_stall_o", hazard_stall_o, 0);
        check_val("wb_valid_o", wb_valid_o, 0);

        for (int r = 0; r < nrow; r++) begin
            if (t_hold[r] > 0) begin
                while (outstanding() != 0) tick();
                tick();
                check_val("atom_lock_o", atom_lock_o, 0);
            end
            issue_op_i    = t_op[r];
            issue_rs1_i   = t_rs1[r];
            issue_rs2_i   = t_rs2[r];
            issue_rd_i    = t_rd[r];
            issue_rd_we_i = t_we[r];
            issue_a_i     = t_fix[r] ? t_a[r] : xorshift();
            issue_b_i     = t_fix[r] ? t_b[r] : (xorshift() >> ((r * 3) % 24));
            issue_valid_i = 1'b1;
            pipe_stall_i  = (t_hold[r] > 0);
            for (int h = 0; h < t_hold[r]; h++) begin
                tick();
                check_val("atom_lock_o", atom_lock_o, 0);  // nothing got in
            end
            pipe_stall_i = 1'b0;
            first    = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                #10;
                if (first && t_fs[r] == 1) check_val("hazard_stall_o", hazard_stall_o, 0);
                if (first && t_fs[r] == 2) check_val("hazard_stall_o", hazard_stall_o, 1);
                first    = 1'b0;
                accepted = !hazard_stall_o;
                tick();
            end
            issue_valid_i = 1'b0;
            // producer must already be written back
            if (t_rs1[r] != 0 && pend[t_rs1[r]]) stop_run("source 1 accepted before its producer");
            if (t_rs2[r] != 0 && pend[t_rs2[r]]) stop_run("source 2 accepted before its producer");
            if (t_we[r] && t_rd[r] != 0) begin
                if (pend[t_rd[r]]) stop_run("second write accepted to a pending register");
                pend[t_rd[r]]     = 1'b1;
                exp_data[t_rd[r]] = expected_result(t_op[r], issue_a_i, issue_b_i);
                is_mul[t_rd[r]]   = !t_op[r][2];
                iss_cyc[t_rd[r]]  = cyc - 1;
            end else begin
                x0_pend++;
            end
            issued++;
            if (outstanding() > 4) stop_run("more than four long ops outstanding");
            check_val("atom_lock_o", atom_lock_o, 1);
            repeat (t_gap[r]) tick();
        end

        while (outstanding() != 0) tick();
        tick();
        check_val("atom_lock_o", atom_lock_o, 0);
        check_val("writeback count", wb_count, issued);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/lx_pkg.sv
hw/long_scoreboard.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/commit_arbiter.sv
hw/long_exec_top.sv
sim/tb_long_exec.sv
